// File: src/dfp_macros.svh
`ifndef DFP_MACROS_SVH
`define DFP_MACROS_SVH

// token field widths
`define DFP_COLOR_W     4
`define DFP_DEST_W      7
`define DFP_DATA_W      16
`define DFP_OP_W        3

// matching memory, addressed by colour plus the low destination bits
`define DFP_MM_ADDR_W   8
`define DFP_MM_DEST_W   4
`define DFP_MM_DEPTH    256

// constant table, one word per destination
`define DFP_CMEM_DEPTH  128

// shift amount taken from operand B
`define DFP_SHAMT_W     4

// output FIFO, also the upstream credit budget
`define DFP_FIFO_DEPTH  4
`define DFP_FIFO_PTR_W  2

// downstream credits after reset
`define DFP_OUT_CREDITS 2

// counters that run up to the FIFO depth
`define DFP_CRED_W      3

`endif

// File: src/dfp_pkg.sv
`include "dfp_macros.svh"

package dfp_pkg;

    // execute stage opcodes
    typedef enum logic [`DFP_OP_W-1:0] {
        // a + b, wraps
        op_add  = 3'd0,
        // a - b, wraps
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        // a shifted left by low bits of b
        op_shl  = 3'd5,
        // a unchanged
        op_pass = 3'd6,
        // unsigned maximum
        op_max  = 3'd7
    } alu_op_e;

    // decision made for each token at the matching stage
    typedef enum logic [1:0] {
        // nothing this cycle
        act_none       = 2'd0,
        // first of a pair, kept in the matching RAM and deleted
        act_store      = 2'd1,
        // second of a pair, merges with the stored operand
        act_fire_pair  = 2'd2,
        // single operand token, merges with the constant table
        act_fire_const = 2'd3
    } match_act_e;

endpackage

// File: src/match_ctrl.sv
`include "dfp_macros.svh"

module match_ctrl (
    input  logic                       CP,
    input  logic                       MR,
    input  logic                       in_valid,
    input  logic [`DFP_COLOR_W-1:0]    in_color,
    input  logic [`DFP_DEST_W-1:0]     in_dest,
    input  logic [`DFP_OP_W-1:0]       in_op,
    input  logic                       in_mf,
    input  logic                       in_lr,
    input  logic [`DFP_DATA_W-1:0]     in_data,
    input  logic                       fifo_credit,
    output dfp_pkg::match_act_e        act,
    output logic [`DFP_MM_ADDR_W-1:0]  mm_addr,
    output logic [`DFP_COLOR_W-1:0]    tk_color,
    output logic [`DFP_DEST_W-1:0]     tk_dest,
    output logic [`DFP_OP_W-1:0]       tk_op,
    output logic                       tk_lr,
    output logic [`DFP_DATA_W-1:0]     tk_data,
    output logic                       in_credit
);

    import dfp_pkg::*;

    // one bit per matching address, set while a partner waits
    logic [`DFP_MM_DEPTH-1:0]   present;
    logic [`DFP_MM_ADDR_W-1:0]  in_addr;
    match_act_e                 nxt_act;

    // credits owed upstream for deleted tokens
    logic [`DFP_CRED_W-1:0]     owed;
    logic [`DFP_CRED_W-1:0]     owed_nxt;
    logic                       owed_ret;

    assign in_addr = {in_color, in_dest[`DFP_MM_DEST_W-1:0]};

    always_comb begin
        nxt_act = act_none;
        if (in_valid) begin
            if (!in_mf) begin
                nxt_act = act_fire_const;
            end else if (present[in_addr]) begin
                nxt_act = act_fire_pair;
            end else begin
                nxt_act = act_store;
            end
        end
    end

    // FIFO credits take the slot, a deleted-token credit waits a cycle
    assign owed_ret  = (owed != '0) && !fifo_credit;
    assign in_credit = fifo_credit || (owed != '0);

    always_comb begin
        owed_nxt = owed;
        if (nxt_act == act_store) begin
            owed_nxt = owed_nxt + `DFP_CRED_W'(1);
        end
        if (owed_ret) begin
            owed_nxt = owed_nxt - `DFP_CRED_W'(1);
        end
    end

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            act     <= act_none;
            present <= '0;
            owed    <= '0;
        end else begin
            act  <= nxt_act;
            owed <= owed_nxt;
            if (nxt_act == act_store) begin
                present[in_addr] <= 1'b1;
            end else if (nxt_act == act_fire_pair) begin
                present[in_addr] <= 1'b0;
            end
        end
    end

    // token fields follow act, qualified by it downstream
    always_ff @(posedge CP) begin
        if (in_valid) begin
            mm_addr  <= in_addr;
            tk_color <= in_color;
            tk_dest  <= in_dest;
            tk_op    <= in_op;
            tk_lr    <= in_lr;
            tk_data  <= in_data;
        end
    end

endmodule

// File: src/mm_stage.sv
`include "dfp_macros.svh"

module mm_stage (
    input  logic                       CP,
    input  logic                       MR,
    input  dfp_pkg::match_act_e        act,
    input  logic [`DFP_MM_ADDR_W-1:0]  mm_addr,
    input  logic [`DFP_COLOR_W-1:0]    tk_color,
    input  logic [`DFP_DEST_W-1:0]     tk_dest,
    input  logic [`DFP_OP_W-1:0]       tk_op,
    input  logic                       tk_lr,
    input  logic [`DFP_DATA_W-1:0]     tk_data,
    output logic                       pair_valid,
    output logic [`DFP_COLOR_W-1:0]    pair_color,
    output logic [`DFP_DEST_W-1:0]     pair_dest,
    output dfp_pkg::alu_op_e           pair_op,
    output logic [`DFP_DATA_W-1:0]     pair_opa,
    output logic [`DFP_DATA_W-1:0]     pair_opb
);

    import dfp_pkg::*;

    logic [`DFP_DATA_W-1:0]   mm_ram [`DFP_MM_DEPTH];
    logic [`DFP_DATA_W-1:0]   cmem   [`DFP_CMEM_DEPTH];

    // registered reads
    logic [`DFP_DATA_W-1:0]   rd_data;
    logic [`DFP_DATA_W-1:0]   cst_data;

    // delay latch, holds the token beside its reads
    match_act_e               dl_act;
    logic [`DFP_COLOR_W-1:0]  dl_color;
    logic [`DFP_DEST_W-1:0]   dl_dest;
    logic [`DFP_OP_W-1:0]     dl_op;
    logic                     dl_lr;
    logic [`DFP_DATA_W-1:0]   dl_data;

    // operand that joins the token, stored or constant
    logic [`DFP_DATA_W-1:0]   partner;

    function automatic logic [`DFP_DATA_W-1:0] const_of(input int idx);
        logic [`DFP_DATA_W-1:0] val;
        case (idx)
            0, 2, 5, 7, 8, 12, 14: val = '0;
            1, 4, 9, 13:           val = `DFP_DATA_W'(1);
            default:               val = `DFP_DATA_W'(idx + 1);
        endcase
        return val;
    endfunction

    // read-only table, fixed contents
    initial begin
        for (int i = 0; i < `DFP_CMEM_DEPTH; i++) begin
            cmem[i] = const_of(i);
        end
    end

    // write and read on one edge, a partner one cycle later sees the write
    always_ff @(posedge CP) begin
        if (act == act_store) begin
            mm_ram[mm_addr] <= tk_data;
        end
        rd_data  <= mm_ram[mm_addr];
        cst_data <= cmem[tk_dest];
    end

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            dl_act <= act_none;
        end else begin
            dl_act <= act;
        end
    end

    always_ff @(posedge CP) begin
        dl_color <= tk_color;
        dl_dest  <= tk_dest;
        dl_op    <= tk_op;
        dl_lr    <= tk_lr;
        dl_data  <= tk_data;
    end

    assign partner = (dl_act == act_fire_pair) ? rd_data : cst_data;

    // right-hand token puts the partner in A
    assign pair_opa = dl_lr ? partner : dl_data;
    assign pair_opb = dl_lr ? dl_data : partner;

    assign pair_valid = (dl_act == act_fire_pair) || (dl_act == act_fire_const);
    assign pair_color = dl_color;
    assign pair_dest  = dl_dest;
    assign pair_op    = alu_op_e'(dl_op);

endmodule

// File: src/alu_stage.sv
`include "dfp_macros.svh"

module alu_stage (
    input  logic                     CP,
    input  logic                     MR,
    input  logic                     pair_valid,
    input  logic [`DFP_COLOR_W-1:0]  pair_color,
    input  logic [`DFP_DEST_W-1:0]   pair_dest,
    input  dfp_pkg::alu_op_e         pair_op,
    input  logic [`DFP_DATA_W-1:0]   pair_opa,
    input  logic [`DFP_DATA_W-1:0]   pair_opb,
    output logic                     res_valid,
    output logic [`DFP_COLOR_W-1:0]  res_color,
    output logic [`DFP_DEST_W-1:0]   res_dest,
    output logic [`DFP_DATA_W-1:0]   res_result
);

    import dfp_pkg::*;

    logic [`DFP_DATA_W-1:0]   alu_out;
    logic [`DFP_SHAMT_W-1:0]  shamt;

    assign shamt = pair_opb[`DFP_SHAMT_W-1:0];

    always_comb begin
        alu_out = '0;
        case (pair_op)
            // add and sub wrap at the operand width
            op_add: begin
                alu_out = pair_opa + pair_opb;
            end
            op_sub: begin
                alu_out = pair_opa - pair_opb;
            end
            op_and: begin
                alu_out = pair_opa & pair_opb;
            end
            op_or: begin
                alu_out = pair_opa | pair_opb;
            end
            op_xor: begin
                alu_out = pair_opa ^ pair_opb;
            end
            op_shl: begin
                alu_out = pair_opa << shamt;
            end
            op_pass: begin
                alu_out = pair_opa;
            end
            op_max: begin
                alu_out = (pair_opa > pair_opb) ? pair_opa : pair_opb;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= pair_valid;
        end
    end

    // colour and destination of the firing token pass through
    always_ff @(posedge CP) begin
        if (pair_valid) begin
            res_color  <= pair_color;
            res_dest   <= pair_dest;
            res_result <= alu_out;
        end
    end

endmodule

// File: src/credit_out.sv
`include "dfp_macros.svh"

module credit_out (
    input  logic                     CP,
    input  logic                     MR,
    input  logic                     res_valid,
    input  logic [`DFP_COLOR_W-1:0]  res_color,
    input  logic [`DFP_DEST_W-1:0]   res_dest,
    input  logic [`DFP_DATA_W-1:0]   res_result,
    input  logic                     out_credit,
    output logic                     out_valid,
    output logic [`DFP_COLOR_W-1:0]  out_color,
    output logic [`DFP_DEST_W-1:0]   out_dest,
    output logic [`DFP_DATA_W-1:0]   out_result,
    output logic                     fifo_credit
);

    logic [`DFP_COLOR_W-1:0]     f_color  [`DFP_FIFO_DEPTH];
    logic [`DFP_DEST_W-1:0]      f_dest   [`DFP_FIFO_DEPTH];
    logic [`DFP_DATA_W-1:0]      f_result [`DFP_FIFO_DEPTH];

    logic [`DFP_FIFO_PTR_W-1:0]  wr_ptr;
    logic [`DFP_FIFO_PTR_W-1:0]  rd_ptr;
    logic [`DFP_CRED_W-1:0]      count;
    // downstream credits in hand
    logic [`DFP_CRED_W-1:0]      credits;
    logic                        deq;

    // never overflows, upstream credits cap the occupancy
    assign deq = (count != '0) && (credits != '0);

    assign out_valid   = deq;
    assign fifo_credit = deq;
    assign out_color   = f_color[rd_ptr];
    assign out_dest    = f_dest[rd_ptr];
    assign out_result  = f_result[rd_ptr];

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= `DFP_CRED_W'(`DFP_OUT_CREDITS);
        end else begin
            if (res_valid) begin
                wr_ptr <= wr_ptr + `DFP_FIFO_PTR_W'(1);
            end
            if (deq) begin
                rd_ptr <= rd_ptr + `DFP_FIFO_PTR_W'(1);
            end
            if (res_valid && !deq) begin
                count <= count + `DFP_CRED_W'(1);
            end else if (!res_valid && deq) begin
                count <= count - `DFP_CRED_W'(1);
            end
            if (out_credit && !deq) begin
                credits <= credits + `DFP_CRED_W'(1);
            end else if (!out_credit && deq) begin
                credits <= credits - `DFP_CRED_W'(1);
            end
        end
    end

    always_ff @(posedge CP) begin
        if (res_valid) begin
            f_color[wr_ptr]  <= res_color;
            f_dest[wr_ptr]   <= res_dest;
            f_result[wr_ptr] <= res_result;
        end
    end

endmodule

// File: src/dfp_match_top.sv
`include "dfp_macros.svh"

module dfp_match_top (
    input  logic                     CP,
    input  logic                     MR,
    input  logic                     in_valid,
    input  logic [`DFP_COLOR_W-1:0]  in_color,
    input  logic [`DFP_DEST_W-1:0]   in_dest,
    input  logic [`DFP_OP_W-1:0]     in_op,
    input  logic                     in_mf,
    input  logic                     in_lr,
    input  logic [`DFP_DATA_W-1:0]   in_data,
    output logic                     in_credit,
    output logic                     out_valid,
    output logic [`DFP_COLOR_W-1:0]  out_color,
    output logic [`DFP_DEST_W-1:0]   out_dest,
    output logic [`DFP_DATA_W-1:0]   out_result,
    input  logic                     out_credit
);

    import dfp_pkg::*;

    // match_ctrl to mm_stage
    match_act_e                 act;
    logic [`DFP_MM_ADDR_W-1:0]  mm_addr;
    logic [`DFP_COLOR_W-1:0]    tk_color;
    logic [`DFP_DEST_W-1:0]     tk_dest;
    logic [`DFP_OP_W-1:0]       tk_op;
    logic                       tk_lr;
    logic [`DFP_DATA_W-1:0]     tk_data;

    // mm_stage to alu_stage
    logic                       pair_valid;
    logic [`DFP_COLOR_W-1:0]    pair_color;
    logic [`DFP_DEST_W-1:0]     pair_dest;
    alu_op_e                    pair_op;
    logic [`DFP_DATA_W-1:0]     pair_opa;
    logic [`DFP_DATA_W-1:0]     pair_opb;

    // alu_stage to credit_out
    logic                       res_valid;
    logic [`DFP_COLOR_W-1:0]    res_color;
    logic [`DFP_DEST_W-1:0]     res_dest;
    logic [`DFP_DATA_W-1:0]     res_result;

    // dequeue credits back to the input side
    logic                       fifo_credit;

    match_ctrl i_match_ctrl (
        .CP, .MR, .in_valid, .in_color, .in_dest, .in_op, .in_mf, .in_lr, .in_data,
        .fifo_credit, .act, .mm_addr, .tk_color, .tk_dest, .tk_op, .tk_lr, .tk_data,
        .in_credit
    );

    mm_stage i_mm_stage (
        .CP, .MR, .act, .mm_addr, .tk_color, .tk_dest, .tk_op, .tk_lr, .tk_data,
        .pair_valid, .pair_color, .pair_dest, .pair_op, .pair_opa, .pair_opb
    );

    alu_stage i_alu_stage (
        .CP, .MR, .pair_valid, .pair_color, .pair_dest, .pair_op, .pair_opa, .pair_opb,
        .res_valid, .res_color, .res_dest, .res_result
    );

    credit_out i_credit_out (
        .CP, .MR, .res_valid, .res_color, .res_dest, .res_result, .out_credit,
        .out_valid, .out_color, .out_dest, .out_result, .fifo_credit
    );

endmodule

// File: tb/dfp_match_chk.sv
`include "dfp_macros.svh"

module dfp_match_chk (
    input  logic  CP,
    input  logic  MR,
    input  logic  in_valid,
    input  logic  in_credit,
    input  logic  out_valid,
    input  logic  out_credit
);

    timeunit 1ns;
    timeprecision 100ps;

    // credit balances rebuilt from the port handshakes
    logic [`DFP_CRED_W:0]  up_cred;
    logic [`DFP_CRED_W:0]  dn_cred;

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            up_cred <= (`DFP_CRED_W+1)'(`DFP_FIFO_DEPTH);
            dn_cred <= (`DFP_CRED_W+1)'(`DFP_OUT_CREDITS);
        end else begin
            up_cred <= up_cred + (`DFP_CRED_W+1)'(in_credit) - (`DFP_CRED_W+1)'(in_valid);
            dn_cred <= dn_cred + (`DFP_CRED_W+1)'(out_credit) - (`DFP_CRED_W+1)'(out_valid);
        end
    end

    a_out_needs_credit: assert property (@(posedge CP) disable iff (MR)
        out_valid |-> dn_cred != '0)
        else $error("out_valid while downstream credits are exhausted");

    a_up_credit_max: assert property (@(posedge CP) disable iff (MR)
        up_cred <= (`DFP_CRED_W+1)'(`DFP_FIFO_DEPTH))
        else $error("upstream credits above the FIFO depth");

endmodule

bind dfp_match_top dfp_match_chk i_dfp_match_chk (.*);

// File: tb/dfp_match_tb.sv
`include "dfp_macros.svh"

module dfp_match_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                     CP;
    logic                     MR;
    logic                     in_valid;
    logic [`DFP_COLOR_W-1:0]  in_color;
    logic [`DFP_DEST_W-1:0]   in_dest;
    logic [`DFP_OP_W-1:0]     in_op;
    logic                     in_mf;
    logic                     in_lr;
    logic [`DFP_DATA_W-1:0]   in_data;
    logic                     in_credit;
    logic                     out_valid;
    logic [`DFP_COLOR_W-1:0]  out_color;
    logic [`DFP_DEST_W-1:0]   out_dest;
    logic [`DFP_DATA_W-1:0]   out_result;
    logic                     out_credit;

    // tag, colour, dest, op, mf, lr, pad, data as hex digits
    logic [47:0]  vec [0:63];
    logic [47:0]  in_q [$];
    logic [47:0]  exp_q [$];
    logic [31:0]  lfsr_state;
    int           up_credits;
    int           dn_debt;
    int           sent;
    int           got;
    int           cycles;
    int           limit;
    int           mismatches;
    int           other_errs;
    bit           done;

    dfp_match_top i_dfp_match_top (.*);

    initial CP = 1'b0;
    always #2 CP = ~CP;

    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = b ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return b;
    endfunction

    task automatic send_token(input logic [47:0] w);
        in_valid = 1'b1;
        in_color = w[43:40];
        in_dest  = w[38:32];
        in_op    = w[30:28];
        in_mf    = w[24];
        in_lr    = w[20];
        in_data  = w[15:0];
    endtask

    task automatic check_result();
        logic [47:0] e;
        if (got >= exp_q.size()) begin
            other_errs++;
            $display("result arrived with no expected result left");
        end else begin
            e = exp_q[got];
            if (out_color !== e[43:40]) begin
                mismatches++;
                $display("FAIL out_color exp %h got %h", e[43:40], out_color);
            end
            if (out_dest !== e[38:32]) begin
                mismatches++;
                $display("FAIL out_dest exp %h got %h", e[38:32], out_dest);
            end
            if (out_result !== e[15:0]) begin
                mismatches++;
                $display("FAIL out_result exp %h got %h", e[15:0], out_result);
            end
            got++;
        end
    endtask

    // outputs settle after the rising edge, sample mid-cycle
    always @(negedge CP) begin
        if (!MR) begin
            cycles++;
            if (sent == 0 && (out_valid || in_credit)) begin
                other_errs++;
                $display("output activity before any token was sent");
            end
            if (in_credit) begin
                up_credits++;
            end
            if (up_credits > `DFP_FIFO_DEPTH) begin
                other_errs++;
                $display("upstream credits rose above the FIFO depth");
            end
            if (out_valid) begin
                check_result();
                dn_debt++;
            end
        end
    end

    initial begin
        lfsr_state = 32'hbed3_d884;
        MR = 1'b1;
        in_valid = 1'b0;
        in_color = '0;
        in_dest = '0;
        in_op = '0;
        in_mf = 1'b0;
        in_lr = 1'b0;
        in_data = '0;
        out_credit = 1'b0;
        up_credits = `DFP_FIFO_DEPTH;
        dn_debt = 0;
        sent = 0;
        got = 0;
        cycles = 0;
        mismatches = 0;
        other_errs = 0;
        done = 1'b0;
        for (int i = 0; i < 64; i++) begin
            vec[i] = '0;
        end
        $readmemh("tb/dfp_testdata.hex", vec);
        for (int i = 0; i < 64; i++) begin
            if (vec[i][47:44] == 4'h1) begin
                in_q.push_back(vec[i]);
            end else if (vec[i][47:44] == 4'h2) begin
                exp_q.push_back(vec[i]);
            end
        end
        limit = 20 * in_q.size() + 200;
        repeat (8) @(posedge CP);
        #1 MR = 1'b0;
        while (!done && cycles < limit) begin
            @(posedge CP);
            #1;
            in_valid = 1'b0;
            out_credit = 1'b0;
            // sparse credit return, roughly one in four cycles
            if (dn_debt > 0 && next_rand_bit() && next_rand_bit()) begin
                out_credit = 1'b1;
                dn_debt--;
            end
            if (sent < in_q.size() && up_credits > 0) begin
                if (!(next_rand_bit() && next_rand_bit())) begin
                    send_token(in_q[sent]);
                    sent++;
                    up_credits--;
                end
            end
            done = (sent == in_q.size()) && (got == exp_q.size()) &&
                   (up_credits == `DFP_FIFO_DEPTH) && (dn_debt == 0);
        end
        if (!done) begin
            other_errs++;
            $display("timeout after %0d cycles, %0d of %0d results seen, %0d credits held",
                     cycles, got, exp_q.size(), up_credits);
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+src
src/dfp_pkg.sv
src/match_ctrl.sv
src/mm_stage.sv
src/alu_stage.sv
src/credit_out.sv
src/dfp_match_top.sv
tb/dfp_match_chk.sv
tb/dfp_match_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= dfp_match_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/dfp_testdata.hex
// tag(1 in, 2 expected) colour dest(2) op mf lr pad data(4)
// expected lines: tag colour dest(2) 0000 result(4), in firing order
110300000010
210300000014
120510100001
22050000FFFF
1009300000F0
2009000000F1
101450000003
201400000060
130A11100005
130A11000100
230A000000FB
140B71001234
140B7110F000
240B0000F000
151221000FF0
16124100AAAA
151221103C3C
251200000C30
161241105555
26120000FFFF
17200100FFFF
17306000BEEF
27300000BEEF
172001100002
272000000001
